// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_ein
FLIST      = flist.f
BUILD_DIR  = obj_dir
VFLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== ein_byte_fetch.sv ====
module ein_byte_fetch (
	input  logic           clk,
	input  logic           bit_ctr_reset,
	input  ein_pkg::ptr_t  wr_ptr,
	output ein_pkg::ptr_t  rd_ptr,
	output ein_pkg::byte_t head_byte,
	output logic           empty,
	input  logic           pop,
	ein_mem_if.requester   fetch_bus
);
	import ein_pkg::*;

	logic  head_valid;
	byte_t head_q;
	logic  ring_has_data;

	assign ring_has_data = (rd_ptr != wr_ptr);

	// ############################
	// Refill request
	// ############################

	// Only asks while the head is invalid, so never two cycles in a row
	assign fetch_bus.req   = ~head_valid & ring_has_data;
	assign fetch_bus.we    = 1'b0;
	assign fetch_bus.addr  = rd_ptr[ADDR_W-1:0];
	assign fetch_bus.wdata = '0;

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			head_valid <= 1'b0;
			rd_ptr     <= '0;
		end else begin
			if (fetch_bus.gnt) begin
				head_valid <= 1'b1;
				rd_ptr     <= rd_ptr + 1'b1;
			end else if (pop) begin
				head_valid <= 1'b0;	// Refill starts next cycle
			end
		end
	end

	// Head payload, loaded straight from the read port
	always_ff @(posedge clk) begin
		if (fetch_bus.gnt) begin
			head_q <= fetch_bus.rdata;
		end
	end

	assign head_byte = head_q;
	assign empty     = ~head_valid;

endmodule

// ==== ein_frame_buffer.sv ====
module ein_frame_buffer (
	input logic        clk,
	ein_mem_if.memory  mem_bus
);
	import ein_pkg::*;

	byte_t mem [BUF_DEPTH];

	// ############################
	// Storage
	// ############################

	always_ff @(posedge clk) begin
		if (mem_bus.we) begin
			mem[mem_bus.addr] <= mem_bus.wdata;
		end
	end

	// Read is combinational, data valid in the grant cycle
	assign mem_bus.rdata = mem[mem_bus.addr];

endmodule

// ==== ein_host_writer.sv ====
module ein_host_writer (
	input  logic           clk,
	input  logic           bit_ctr_reset,
	input  logic           wr_en,
	input  ein_pkg::byte_t wr_data,
	output logic           full,
	input  ein_pkg::ptr_t  rd_ptr,
	output ein_pkg::ptr_t  wr_ptr,
	ein_mem_if.requester   write_bus
);
	import ein_pkg::*;

	logic  pend_valid;
	byte_t pend_data;
	ptr_t  fill;
	logic  ring_full;
	logic  accept;

	// Occupancy, wrap bit set once BUF_DEPTH bytes are held
	assign fill      = wr_ptr - rd_ptr;
	assign ring_full = fill[PTR_W-1];

	assign full   = pend_valid | ring_full;
	assign accept = wr_en & ~full;

	// Pending byte stays on the bus until granted
	assign write_bus.req   = pend_valid;
	assign write_bus.we    = 1'b1;
	assign write_bus.addr  = wr_ptr[ADDR_W-1:0];
	assign write_bus.wdata = pend_data;

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			pend_valid <= 1'b0;
			wr_ptr     <= '0;
		end else begin
			if (accept) begin
				pend_valid <= 1'b1;
			end else if (write_bus.gnt) begin
				pend_valid <= 1'b0;
				wr_ptr     <= wr_ptr + 1'b1;	// Byte is in memory at this edge
			end
		end
	end

	// Payload register
	always_ff @(posedge clk) begin
		if (accept) begin
			pend_data <= wr_data;
		end
	end

endmodule

// ==== ein_mem_arbiter.sv ====
module ein_mem_arbiter (
	input logic            clk,
	input logic            bit_ctr_reset,
	ein_mem_if.arbiter     fetch_bus,
	ein_mem_if.arbiter     write_bus,
	ein_mem_if.requester   mem_bus
);
	logic last_win_fetch;	// Fetch owned the port last cycle

	// Fixed priority, fetch refill latency sets serial timing
	assign fetch_bus.gnt = fetch_bus.req;
	assign write_bus.gnt = write_bus.req & ~fetch_bus.req;

	// Read data goes back to both sides, only the granted one uses it
	assign fetch_bus.rdata = mem_bus.rdata;
	assign write_bus.rdata = mem_bus.rdata;

	always_comb begin
		if (fetch_bus.req) begin
			mem_bus.req   = 1'b1;
			mem_bus.we    = fetch_bus.we;
			mem_bus.addr  = fetch_bus.addr;
			mem_bus.wdata = fetch_bus.wdata;
		end else begin
			mem_bus.req   = write_bus.req;
			mem_bus.we    = write_bus.req & write_bus.we;	// No stray writes when idle
			mem_bus.addr  = write_bus.addr;
			mem_bus.wdata = write_bus.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			last_win_fetch <= 1'b0;
		end else begin
			last_win_fetch <= fetch_bus.gnt;
		end
	end

endmodule

// ==== ein_mem_if.sv ====
interface ein_mem_if;
	import ein_pkg::*;

	logic  req;
	logic  we;
	addr_t addr;
	byte_t wdata;
	logic  gnt;
	byte_t rdata;

	// Client side, holds req and fields until gnt
	modport requester (output req, we, addr, wdata, input gnt, rdata);

	// Arbiter side, mirror of requester
	modport arbiter (input req, we, addr, wdata, output gnt, rdata);

	// Storage side
	modport memory (input we, addr, wdata, output rdata);

endinterface

// ==== ein_pkg.sv ====
package ein_pkg;

	// ############################
	// Serial timing
	// ############################

	localparam int CLK_DIV   = 8;	// Cycles per bit phase, thousands on silicon
	localparam int CLK_DIV_W = 4;	// Phase counter width

	// ############################
	// Ring buffer geometry
	// ############################

	localparam int BUF_DEPTH = 16;
	localparam int ADDR_W    = 4;
	localparam int PTR_W     = ADDR_W + 1;	// Extra wrap bit tells full from empty

	typedef logic [7:0]        byte_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [PTR_W-1:0]  ptr_t;

	// Frame FSM, four phases per bit
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_NEG1,
		ST_NEG2,
		ST_POS1,
		ST_POS2,
		ST_FRAG_WAIT
	} tx_state_t;

endpackage

// ==== ein_serializer.sv ====
module ein_serializer (
	input  logic           clk,
	input  logic           bit_ctr_reset,
	input  ein_pkg::byte_t head_byte,
	input  logic           empty,
	output logic           pop,
	input  logic           start_tx,
	input  logic           fragment,
	output logic           emo,
	output logic           edi,
	output logic           eci
);
	import ein_pkg::*;

	tx_state_t            state;
	tx_state_t            next_state;
	logic [CLK_DIV_W-1:0] phase_cnt;
	logic [2:0]           bit_cnt;
	logic                 next_emo;
	logic                 next_edi;
	logic                 next_eci;
	logic                 bit_inc;
	logic                 bit_clr;
	logic                 phase_end;
	logic                 phase_pop;

	assign phase_end = (phase_cnt == CLK_DIV_W'(CLK_DIV - 1));
	assign phase_pop = (phase_cnt == CLK_DIV_W'(CLK_DIV - 3));

	// Last bit advances the counter, head is released to the fetch unit
	assign pop = bit_inc & (bit_cnt == 3'd7);

	// ############################
	// State and line registers
	// ############################

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			state     <= ST_IDLE;
			phase_cnt <= '0;
			bit_cnt   <= '0;
			emo       <= 1'b0;
			edi       <= 1'b0;
			eci       <= 1'b0;
		end else begin
			state <= next_state;
			emo   <= next_emo;
			edi   <= next_edi;
			eci   <= next_eci;
			if (next_state != state) begin
				phase_cnt <= '0;	// Each phase starts from zero
			end else begin
				phase_cnt <= phase_cnt + 1'b1;
			end
			if (bit_clr) begin
				bit_cnt <= '0;
			end else if (bit_inc) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// ############################
	// Next state and line values
	// ############################

	always_comb begin
		next_state = state;
		next_emo   = 1'b1;	// High through the whole frame
		next_edi   = 1'b0;
		next_eci   = 1'b0;
		bit_inc    = 1'b0;
		bit_clr    = 1'b0;
		case (state)
			ST_IDLE: begin
				next_emo = start_tx;	// emo rises the cycle after the strobe
				if (start_tx) begin
					next_state = ST_START;
				end
			end
			ST_START: begin
				bit_clr = 1'b1;
				if (phase_end) begin
					next_state = ST_NEG1;
				end
			end
			ST_NEG1: begin
				next_edi = edi;
				if (phase_end) begin
					next_state = ST_NEG2;
				end
			end
			ST_NEG2: begin
				next_edi = head_byte[bit_cnt];	// LSB first
				if (phase_end) begin
					next_state = ST_POS1;
				end
			end
			ST_POS1: begin
				next_eci = 1'b1;
				next_edi = head_byte[bit_cnt];
				if (phase_end) begin
					next_state = ST_POS2;
				end
			end
			ST_POS2: begin
				next_eci = 1'b1;
				next_edi = edi;
				if (phase_pop) begin
					bit_inc = 1'b1;
				end else if (phase_end) begin
					// Two cycles after the pop, empty reflects the refill
					if (empty && fragment) begin
						next_state = ST_FRAG_WAIT;
					end else if (empty) begin
						next_state = ST_IDLE;
					end else begin
						next_state = ST_NEG1;
					end
				end
			end
			ST_FRAG_WAIT: begin
				if (start_tx) begin
					next_state = ST_START;
				end
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

endmodule

// ==== ein_top.sv ====
module ein_top (
	input  logic           clk,
	input  logic           bit_ctr_reset,
	input  logic           wr_en,
	input  ein_pkg::byte_t wr_data,
	output logic           full,
	input  logic           start_tx,
	input  logic           fragment,
	output logic           emo,
	output logic           edi,
	output logic           eci
);
	import ein_pkg::*;

	ptr_t  wr_ptr;
	ptr_t  rd_ptr;
	byte_t head_byte;
	logic  empty;
	logic  pop;

	ein_mem_if fetch_bus ();
	ein_mem_if write_bus ();
	ein_mem_if mem_bus ();

	// ############################
	// Buffer side
	// ############################

	ein_mem_arbiter i_arbiter (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.fetch_bus     (fetch_bus.arbiter),
		.write_bus     (write_bus.arbiter),
		.mem_bus       (mem_bus.requester)
	);

	ein_frame_buffer i_buffer (
		.clk     (clk),
		.mem_bus (mem_bus.memory)
	);

	ein_host_writer i_writer (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.full          (full),
		.rd_ptr        (rd_ptr),
		.wr_ptr        (wr_ptr),
		.write_bus     (write_bus.requester)
	);

	ein_byte_fetch i_fetch (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.wr_ptr        (wr_ptr),
		.rd_ptr        (rd_ptr),
		.head_byte     (head_byte),
		.empty         (empty),
		.pop           (pop),
		.fetch_bus     (fetch_bus.requester)
	);

	// Serial line side
	ein_serializer i_serializer (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.head_byte     (head_byte),
		.empty         (empty),
		.pop           (pop),
		.start_tx      (start_tx),
		.fragment      (fragment),
		.emo           (emo),
		.edi           (edi),
		.eci           (eci)
	);

endmodule

// ==== flist.f ====
ein_pkg.sv
ein_mem_if.sv
ein_mem_arbiter.sv
ein_frame_buffer.sv
ein_host_writer.sv
ein_byte_fetch.sv
ein_serializer.sv
ein_top.sv
tb_ein_asserts.sv
tb_ein.sv

// ==== tb_ein.sv ====
module tb_ein;
	timeunit 1ns;
	timeprecision 1ps;
	import ein_pkg::*;

	typedef struct packed {
		logic [7:0] n_bytes;
		logic       frag;
		logic       start_early;	// start_tx goes out ahead of the writes
		logic [3:0] seed_idx;
	} frame_t;

	localparam int N_FRAMES = 6;
	localparam int LCG_SEED = 69516;

	frame_t frames [N_FRAMES] = '{
		'{8'd3,  1'b0, 1'b0, 4'd1},	// Plain frame
		'{8'd2,  1'b1, 1'b0, 4'd2},	// Pauses in fragment wait
		'{8'd4,  1'b0, 1'b1, 4'd3},	// Resumes, start ahead of data
		'{8'd20, 1'b0, 1'b0, 4'd4},	// Fills the ring before start
		'{8'd24, 1'b1, 1'b1, 4'd5},	// Writes contend with refills
		'{8'd5,  1'b0, 1'b0, 4'd6}
	};

	logic        clk;
	logic        bit_ctr_reset;
	logic        wr_en;
	byte_t       wr_data;
	logic        full;
	logic        start_tx;
	logic        fragment;
	logic        emo;
	logic        edi;
	logic        eci;

	byte_t       exp_q [$];
	int          cycle_cnt;
	int          rx_count;
	int          rx_bits;
	int          since_rise;
	int          high_cnt;
	logic [7:0]  rx_shift;
	logic        eci_q;
	logic        seg_first;	// Next eci rise opens a new segment
	logic [31:0] lcg_state;

	ein_top i_dut (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.full          (full),
		.start_tx      (start_tx),
		.fragment      (fragment),
		.emo           (emo),
		.edi           (edi),
		.eci           (eci)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ##############################
	// Helpers
	// ##############################

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int cycle_limit();
		int sum;
		sum = 100;	// Reset and idle check
		for (int i = 0; i < N_FRAMES; i++) begin
			sum += frames[i].n_bytes * 32 * CLK_DIV + 200;
		end
		return sum;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Error %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic pulse_start();
		seg_first = 1'b1;
		start_tx  = 1'b1;
		next_cycle();
		start_tx  = 1'b0;
	endtask

	task automatic write_byte(input byte_t b);
		while (full) begin
			next_cycle();
		end
		wr_en   = 1'b1;
		wr_data = b;
		exp_q.push_back(b);
		next_cycle();
		wr_en   = 1'b0;
	endtask

	// Lines between frames, eci and edi low, emo by frame state
	task automatic check_quiet_lines(input int cycles, input logic emo_exp);
		repeat (cycles) begin
			check_value("emo", 32'(emo), 32'(emo_exp));
			check_value("eci", 32'(eci), 32'd0);
			check_value("edi", 32'(edi), 32'd0);
			check_value("full", 32'(full), 32'd0);
			next_cycle();
		end
	endtask

	// ##############################
	// Serial line decoder
	// ##############################

	always @(negedge clk) begin
		if (!bit_ctr_reset) begin
			since_rise++;
			if (eci) begin
				high_cnt++;
			end
			if (eci && !eci_q) begin
				check_value("emo", 32'(emo), 32'd1);
				if (!seg_first) begin
					check_value("bit period", since_rise, 4 * CLK_DIV);
				end
				seg_first  = 1'b0;
				since_rise = 0;
				rx_shift   = {edi, rx_shift[7:1]};	// LSB arrives first
				rx_bits++;
				if (rx_bits == 8) begin
					rx_bits = 0;
					if (exp_q.size() == 0) begin
						fail_run("The serial line sent a byte that was never written");
					end else begin
						check_value("rx byte", 32'(rx_shift), 32'(exp_q.pop_front()));
						rx_count++;
					end
				end
			end
			if (!eci && eci_q) begin
				check_value("eci high time", high_cnt, 2 * CLK_DIV);
				high_cnt = 0;
			end
			eci_q = eci;
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit()) begin
			fail_run("The run went past its cycle limit without finishing the frames");
		end
	end

	// ##############################
	// Stimulus
	// ##############################

	initial begin
		logic started;
		int   rx_before;
		int   rx_target;
		bit_ctr_reset = 1'b1;
		wr_en         = 1'b0;
		wr_data       = '0;
		start_tx      = 1'b0;
		fragment      = 1'b0;
		cycle_cnt     = 0;
		rx_count      = 0;
		rx_bits       = 0;
		since_rise    = 0;
		high_cnt      = 0;
		rx_shift      = '0;
		eci_q         = 1'b0;
		seg_first     = 1'b1;
		lcg_state     = LCG_SEED;
		repeat (5) next_cycle();
		bit_ctr_reset = 1'b0;
		check_quiet_lines(20, 1'b0);	// Nothing moves without start_tx

		for (int f = 0; f < N_FRAMES; f++) begin
			repeat (frames[f].seed_idx) lcg_state = lcg_next(lcg_state);
			rx_target = rx_count + frames[f].n_bytes;
			fragment  = frames[f].frag;
			started   = frames[f].start_early;
			if (started) begin
				pulse_start();
			end
			for (int i = 0; i < frames[f].n_bytes; i++) begin
				if (!started && i == BUF_DEPTH + 1) begin
					// Ring plus head register are full, nothing drains yet
					repeat (2 * CLK_DIV) begin
						check_value("full", 32'(full), 32'd1);
						next_cycle();
					end
					rx_before = rx_count;
					pulse_start();
					started = 1'b1;
					while (full) begin
						next_cycle();
					end
					check_value("bytes sent before full fell", 32'(rx_count - rx_before), 32'd1);
				end
				lcg_state = lcg_next(lcg_state);
				write_byte(lcg_state[23:16]);
			end
			if (!started) begin
				pulse_start();
			end
			while (rx_count < rx_target) begin
				next_cycle();
			end
			repeat (2 * CLK_DIV + 4) next_cycle();
			check_quiet_lines(CLK_DIV, frames[f].frag);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== tb_ein_asserts.sv ====
module tb_ein_asserts (
	input logic clk,
	input logic bit_ctr_reset,
	input logic wr_en,
	input logic full,
	input logic emo,
	input logic edi,
	input logic eci,
	input logic fetch_gnt,
	input logic write_gnt,
	input logic write_req,
	input logic last_win_fetch
);
	timeunit 1ns;
	timeprecision 1ps;

	// Serial clock only inside a frame
	a_eci_in_frame : assert property (@(posedge clk) disable iff (bit_ctr_reset)
		eci |-> emo)
		else $error("eci high while emo is low");

	a_no_write_when_full : assert property (@(posedge clk) disable iff (bit_ctr_reset)
		wr_en |-> !full)
		else $error("wr_en strobed while full is high");

	a_one_grant : assert property (@(posedge clk) disable iff (bit_ctr_reset)
		!(fetch_gnt && write_gnt))
		else $error("fetch and write granted in the same cycle");

	// A waiting writer gets the port right after a fetch win
	a_writer_not_starved : assert property (@(posedge clk) disable iff (bit_ctr_reset)
		(write_req && last_win_fetch) |-> write_gnt)
		else $error("writer kept waiting after a fetch grant");

	// Data holds while eci is high so the receiver samples a settled bit
	a_edi_stable : assert property (@(posedge clk) disable iff (bit_ctr_reset)
		(eci && $past(eci)) |-> $stable(edi))
		else $error("edi changed while eci is high");

endmodule

bind ein_top tb_ein_asserts i_asserts (
	.clk            (clk),
	.bit_ctr_reset  (bit_ctr_reset),
	.wr_en          (wr_en),
	.full           (full),
	.emo            (emo),
	.edi            (edi),
	.eci            (eci),
	.fetch_gnt      (fetch_bus.gnt),
	.write_gnt      (write_bus.gnt),
	.write_req      (write_bus.req),
	.last_win_fetch (i_arbiter.last_win_fetch)
);
